/* verilog/adc_snap_pkg.sv */
/*
 * ADC snapshot capture, shared definitions
 * Sample word layout, the capture write command, the buffer read request,
 * the Wishbone address map fields and the address region decode enum.
 */
`default_nettype none

package adc_snap_pkg;

  // one channel delivers SAMPLES_PER_WORD samples of SAMPLE_BITS per user_clk
  localparam int SAMPLE_BITS      = 8;
  localparam int SAMPLES_PER_WORD = 8;
  localparam int ADC_WORD_BITS    = SAMPLE_BITS * SAMPLES_PER_WORD;

  // default snapshot depth is 2**SNAP_AW words per channel
  localparam int SNAP_AW = 6;
  localparam int CH_BITS = 2;

  // Wishbone widths, byte addressed
  localparam int WB_AW = 12;
  localparam int WB_DW = 32;
  localparam int WB_SW = WB_DW / 8;

  // ##########################################################################
  // address map fields
  // ##########################################################################
  localparam int ADR_HALF_BIT = 2;
  localparam int ADR_WORD_LSB = 3;
  localparam int ADR_CH_LSB   = 9;
  localparam int ADR_BUF_BIT  = 11;

  typedef logic [SAMPLES_PER_WORD-1:0][SAMPLE_BITS-1:0] adc_word_t;

  typedef struct packed {
    logic               we;
    logic [SNAP_AW-1:0] addr;
  } snap_wr_t;

  // half selects the low (0) or high (1) 32 bits of a buffer entry
  typedef struct packed {
    logic               valid;
    logic [CH_BITS-1:0] ch;
    logic [SNAP_AW-1:0] word;
    logic               half;
  } buf_rd_req_t;

  typedef enum logic [1:0] {
    REG_CTRL,
    REG_BUF,
    REG_NONE
  } wb_region_e;

endpackage

`default_nettype wire

/* verilog/wb_snap_regs.sv */
/*
 * Wishbone slave for the snapshot subsystem
 * Decodes the byte address into control, buffer or unmapped regions,
 * holds the snapshot control register and answers with ack or err.
 * Buffer reads are forwarded as a one-cycle request and acked when the
 * readout returns the data.
 */
`default_nettype none

module wb_snap_regs
  import adc_snap_pkg::*;
#(
  parameter int NUM_CH = 4
) (
  input  wire logic             user_clk,
  input  wire logic             rst,
  input  wire logic [WB_AW-1:0] wb_adr_i,
  input  wire logic [WB_DW-1:0] wb_dat_i,
  input  wire logic [WB_SW-1:0] wb_sel_i,
  input  wire logic             wb_we_i,
  input  wire logic             wb_cyc_i,
  input  wire logic             wb_stb_i,
  output logic      [WB_DW-1:0] wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  wb_err_o,
  output logic                  snap_req_o,
  output buf_rd_req_t           rd_req_o,
  input  wire logic [WB_DW-1:0] rd_data_i,
  input  wire logic             rd_done_i
);

  wb_region_e       region;
  logic [WB_DW-1:0] ctrl_q;
  logic [WB_DW-1:0] dat_q;
  logic             ack_q;
  logic             err_q;
  logic             busy_q;
  logic             snap_req_q;
  buf_rd_req_t      rd_req_q;
  logic             new_req;
  logic             buf_ack;

  // ##########################################################################
  // address decode
  // ##########################################################################

  // buffers are read only, so a write there falls through to REG_NONE
  always_comb
  begin
    region = REG_NONE;
    if (wb_adr_i[ADR_BUF_BIT:ADR_HALF_BIT] == '0)
    begin
      region = REG_CTRL;
    end
    else if (wb_adr_i[ADR_BUF_BIT] && !wb_we_i &&
             int'(wb_adr_i[ADR_CH_LSB +: CH_BITS]) < NUM_CH)
    begin
      region = REG_BUF;
    end
  end

  // a new access is taken only when nothing is being answered or pending
  assign new_req = wb_cyc_i && wb_stb_i && !ack_q && !err_q && !busy_q;
  assign buf_ack = busy_q && rd_done_i;

  // ##########################################################################
  // control register and responses
  // ##########################################################################
  always_ff @(posedge user_clk)
  begin
    if (rst)
    begin
      ctrl_q         <= '0;
      ack_q          <= 1'b0;
      err_q          <= 1'b0;
      busy_q         <= 1'b0;
      snap_req_q     <= 1'b0;
      rd_req_q.valid <= 1'b0;
    end
    else
    begin
      ack_q          <= 1'b0;
      err_q          <= 1'b0;
      rd_req_q.valid <= 1'b0;
      // one extra stage keeps the capture start at ack plus three cycles
      snap_req_q     <= ctrl_q[0];
      if (buf_ack)
      begin
        busy_q <= 1'b0;
      end
      if (new_req)
      begin
        unique case (region)
          REG_CTRL:
          begin
            ack_q <= 1'b1;
            if (wb_we_i)
            begin
              dat_q <= '0;
              for (int b = 0; b < WB_SW; b++)
              begin
                if (wb_sel_i[b])
                begin
                  ctrl_q[8*b +: 8] <= wb_dat_i[8*b +: 8];
                end
              end
            end
            else
            begin
              dat_q <= ctrl_q;
            end
          end
          REG_BUF:
          begin
            busy_q         <= 1'b1;
            rd_req_q.valid <= 1'b1;
            rd_req_q.ch    <= wb_adr_i[ADR_CH_LSB +: CH_BITS];
            rd_req_q.word  <= wb_adr_i[ADR_WORD_LSB +: SNAP_AW];
            rd_req_q.half  <= wb_adr_i[ADR_HALF_BIT];
          end
          default:
          begin
            err_q <= 1'b1;
          end
        endcase
      end
    end
  end

  assign snap_req_o = snap_req_q;
  assign rd_req_o   = rd_req_q;
  assign wb_ack_o   = ack_q || buf_ack;
  assign wb_err_o   = err_q;

  // data bus stays at zero outside an ack
  assign wb_dat_o = ack_q ? dat_q : (buf_ack ? rd_data_i : '0);

endmodule

`default_nettype wire

/* verilog/snap_sequencer.sv */
/*
 * Snapshot capture sequencer
 * Detects the falling edge of snap_req and runs a counter that opens a
 * write window of 2**SNAP_AW cycles, broadcast to every channel buffer.
 */
`default_nettype none

module snap_sequencer
  import adc_snap_pkg::*;
#(
  parameter int SNAP_AW = adc_snap_pkg::SNAP_AW
) (
  input  wire logic user_clk,
  input  wire logic rst,
  input  wire logic snap_req_i,
  output snap_wr_t  snap_wr_o
);

  logic [1:0]       req_sr;
  // top bit set means the window is closed
  logic [SNAP_AW:0] cnt_q;

  // two-stage history of snap_req for the 1-then-0 pattern
  always_ff @(posedge user_clk)
  begin
    if (rst)
    begin
      req_sr <= 2'b00;
    end
    else
    begin
      req_sr <= {req_sr[0], snap_req_i};
    end
  end

  // the low bits wrap into the top bit, which then holds until a new falling edge
  always_ff @(posedge user_clk)
  begin
    if (rst)
    begin
      cnt_q <= '0;
    end
    else if (req_sr == 2'b10)
    begin
      cnt_q <= '0;
    end
    else if (!cnt_q[SNAP_AW])
    begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_comb
  begin
    snap_wr_o                    = '0;
    snap_wr_o.we                 = ~cnt_q[SNAP_AW];
    snap_wr_o.addr[SNAP_AW-1:0]  = cnt_q[SNAP_AW-1:0];
  end

endmodule

`default_nettype wire

/* verilog/snap_buffer.sv */
/*
 * Snapshot buffer for one ADC channel
 * Simple dual-port RAM of 2**SNAP_AW sample words, written by the capture
 * sequencer and read through a registered port for block RAM inference.
 */
`default_nettype none

module snap_buffer
  import adc_snap_pkg::*;
#(
  parameter int SNAP_AW = adc_snap_pkg::SNAP_AW
) (
  input  wire logic               user_clk,
  input  wire snap_wr_t           snap_wr_i,
  input  wire adc_word_t          din_i,
  input  wire logic [SNAP_AW-1:0] rd_addr_i,
  output adc_word_t               rd_data_o
);

  adc_word_t mem [2**SNAP_AW];

  // capture port
  always_ff @(posedge user_clk)
  begin
    if (snap_wr_i.we)
    begin
      mem[snap_wr_i.addr[SNAP_AW-1:0]] <= din_i;
    end
  end

  // read port, one cycle of latency
  always_ff @(posedge user_clk)
  begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

`default_nettype wire

/* verilog/snap_readout.sv */
/*
 * Snapshot readout path
 * Drives the word address to all channel buffers, waits out the RAM
 * latency and returns the selected channel's 32-bit half with a done pulse.
 */
`default_nettype none

module snap_readout
  import adc_snap_pkg::*;
#(
  parameter int NUM_CH  = 4,
  parameter int SNAP_AW = adc_snap_pkg::SNAP_AW
) (
  input  wire logic                     user_clk,
  input  wire logic                     rst,
  input  wire buf_rd_req_t              rd_req_i,
  output logic      [SNAP_AW-1:0]       rd_addr_o,
  input  wire adc_word_t [NUM_CH-1:0]   buf_data_i,
  output logic      [WB_DW-1:0]         rd_data_o,
  output logic                          rd_done_o
);

  logic                     s1_valid;
  logic [CH_BITS-1:0]       s1_ch;
  logic                     s1_half;
  logic [ADC_WORD_BITS-1:0] sel_word;

  // every buffer sees the same address, the channel is picked afterwards
  assign rd_addr_o = rd_req_i.word[SNAP_AW-1:0];

  // stage 1 lines the request up with the RAM output
  always_ff @(posedge user_clk)
  begin
    if (rst)
    begin
      s1_valid <= 1'b0;
    end
    else
    begin
      s1_valid <= rd_req_i.valid;
    end
    s1_ch   <= rd_req_i.ch;
    s1_half <= rd_req_i.half;
  end

  assign sel_word = buf_data_i[s1_ch];

  // stage 2 registers the chosen half
  always_ff @(posedge user_clk)
  begin
    if (rst)
    begin
      rd_done_o <= 1'b0;
    end
    else
    begin
      rd_done_o <= s1_valid;
    end
    if (s1_half)
    begin
      rd_data_o <= sel_word[WB_DW +: WB_DW];
    end
    else
    begin
      rd_data_o <= sel_word[0 +: WB_DW];
    end
  end

endmodule

`default_nettype wire

/* verilog/adc_snap_top.sv */
/*
 * Snapshot capture subsystem for a four-channel 16 GSps ADC
 * Wishbone control and readout, a capture sequencer and one snapshot
 * buffer per channel, all on user_clk.
 */
`default_nettype none

module adc_snap_top
  import adc_snap_pkg::*;
#(
  parameter int NUM_CH  = 4,
  parameter int SNAP_AW = adc_snap_pkg::SNAP_AW
) (
  input  wire logic                   user_clk,
  input  wire logic                   rst,
  input  wire logic [WB_AW-1:0]       wb_adr_i,
  input  wire logic [WB_DW-1:0]       wb_dat_i,
  input  wire logic [WB_SW-1:0]       wb_sel_i,
  input  wire logic                   wb_we_i,
  input  wire logic                   wb_cyc_i,
  input  wire logic                   wb_stb_i,
  output logic      [WB_DW-1:0]       wb_dat_o,
  output logic                        wb_ack_o,
  output logic                        wb_err_o,
  input  wire adc_word_t [NUM_CH-1:0] adc_data_i
);

  logic                   snap_req;
  snap_wr_t               snap_wr;
  buf_rd_req_t            rd_req;
  logic [SNAP_AW-1:0]     rd_addr;
  adc_word_t [NUM_CH-1:0] buf_data;
  logic [WB_DW-1:0]       rd_data;
  logic                   rd_done;

  wb_snap_regs #(
    .NUM_CH (NUM_CH)
  ) u_regs (
    .user_clk   (user_clk),
    .rst        (rst),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_sel_i   (wb_sel_i),
    .wb_we_i    (wb_we_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .wb_err_o   (wb_err_o),
    .snap_req_o (snap_req),
    .rd_req_o   (rd_req),
    .rd_data_i  (rd_data),
    .rd_done_i  (rd_done)
  );

  snap_sequencer #(
    .SNAP_AW (SNAP_AW)
  ) u_seq (
    .user_clk   (user_clk),
    .rst        (rst),
    .snap_req_i (snap_req),
    .snap_wr_o  (snap_wr)
  );

  // ##########################################################################
  // one buffer per channel, all written in the same window
  // ##########################################################################
  for (genvar c = 0; c < NUM_CH; c++)
  begin : g_buf
    snap_buffer #(
      .SNAP_AW (SNAP_AW)
    ) u_buf (
      .user_clk  (user_clk),
      .snap_wr_i (snap_wr),
      .din_i     (adc_data_i[c]),
      .rd_addr_i (rd_addr),
      .rd_data_o (buf_data[c])
    );
  end

  snap_readout #(
    .NUM_CH  (NUM_CH),
    .SNAP_AW (SNAP_AW)
  ) u_readout (
    .user_clk   (user_clk),
    .rst        (rst),
    .rd_req_i   (rd_req),
    .rd_addr_o  (rd_addr),
    .buf_data_i (buf_data),
    .rd_data_o  (rd_data),
    .rd_done_o  (rd_done)
  );

endmodule

`default_nettype wire

/* testbench/adc_snap_assert.sv */
/*
 * Bus and capture timing checks for the snapshot subsystem
 * Bound into adc_snap_top. Covers ack and err exclusivity, one-cycle
 * responses, the data bus idle value and the capture window length.
 */
`default_nettype none

module adc_snap_assert
  import adc_snap_pkg::*;
#(
  parameter int SNAP_AW = adc_snap_pkg::SNAP_AW
) (
  input wire logic             user_clk,
  input wire logic             rst,
  input wire logic             wb_ack_i,
  input wire logic             wb_err_i,
  input wire logic [WB_DW-1:0] wb_dat_i,
  input wire snap_wr_t         snap_wr_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // write cycles since the window last started at address 0
  int we_run;

  always_ff @(posedge user_clk)
  begin
    if (rst)
    begin
      we_run <= 0;
    end
    else if (snap_wr_i.we && snap_wr_i.addr[SNAP_AW-1:0] == '0)
    begin
      // a trigger during an open window restarts it here
      we_run <= 1;
    end
    else if (snap_wr_i.we)
    begin
      we_run <= we_run + 1;
    end
    else
    begin
      we_run <= 0;
    end
  end

  a_ack_err_excl: assert property (@(posedge user_clk) disable iff (rst)
    !(wb_ack_i && wb_err_i))
    else $error("ack and err are high in the same cycle");

  a_ack_pulse: assert property (@(posedge user_clk) disable iff (rst)
    wb_ack_i |=> !wb_ack_i)
    else $error("ack is high for more than one cycle");

  a_err_pulse: assert property (@(posedge user_clk) disable iff (rst)
    wb_err_i |=> !wb_err_i)
    else $error("err is high for more than one cycle");

  a_we_window: assert property (@(posedge user_clk) disable iff (rst)
    $fell(snap_wr_i.we) |-> we_run == 2**SNAP_AW)
    else $error("capture window length differs from the buffer depth");

  a_dat_idle: assert property (@(posedge user_clk) disable iff (rst)
    !wb_ack_i |-> wb_dat_i == '0)
    else $error("read data is not zero outside an ack");

endmodule

bind adc_snap_top adc_snap_assert #(
  .SNAP_AW (SNAP_AW)
) u_assert (
  .user_clk  (user_clk),
  .rst       (rst),
  .wb_ack_i  (wb_ack_o),
  .wb_err_i  (wb_err_o),
  .wb_dat_i  (wb_dat_o),
  .snap_wr_i (snap_wr)
);

`default_nettype wire

/* testbench/adc_snap_tb.sv */
/*
 * Testbench for the ADC snapshot capture subsystem
 * Runs Wishbone operations from the golden file, feeds LCG sample words to
 * every channel and checks control reads, buffer contents, ack latency
 * and err responses against a cycle-indexed sample model.
 */
`default_nettype none

module adc_snap_tb
  import adc_snap_pkg::*;
#(
  parameter int NUM_CH  = 4,
  parameter int SNAP_AW = adc_snap_pkg::SNAP_AW
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    DEPTH       = 2**SNAP_AW;
  localparam int    CLK_HALF    = 50;
  localparam int    RST_CYCLES  = 16;
  localparam int    WINDOW_WAIT = DEPTH + 6;
  localparam int    RESP_LIMIT  = 8;
  localparam int    MARGIN      = 200;
  localparam string GOLDEN      = "testbench/adc_snap_golden.txt";

  logic                   user_clk;
  logic                   rst;
  logic [WB_AW-1:0]       wb_adr_i;
  logic [WB_DW-1:0]       wb_dat_i;
  logic [WB_SW-1:0]       wb_sel_i;
  logic                   wb_we_i;
  logic                   wb_cyc_i;
  logic                   wb_stb_i;
  logic [WB_DW-1:0]       wb_dat_o;
  logic                   wb_ack_o;
  logic                   wb_err_o;
  adc_word_t [NUM_CH-1:0] adc_data_i = '0;

  int          cyc_cnt   = 0;
  int          run_limit = 0;
  int          last_a    = -1;
  logic [31:0] lcg_state = 32'h5d32;

  // every driven sample word, indexed by the cycle it was present in
  adc_word_t [NUM_CH-1:0] model [];
  logic [7:0]             op_code [$];
  logic [31:0]            op_a [$];
  logic [31:0]            op_b [$];

  adc_snap_top #(
    .NUM_CH  (NUM_CH),
    .SNAP_AW (SNAP_AW)
  ) DUT (
    .user_clk   (user_clk),
    .rst        (rst),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_sel_i   (wb_sel_i),
    .wb_we_i    (wb_we_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .wb_err_o   (wb_err_o),
    .adc_data_i (adc_data_i)
  );

  initial
  begin
    user_clk = 1'b0;
    forever
    begin
      #CLK_HALF user_clk = ~user_clk;
    end
  end

  // cycle index changes on the rising edge and is read on the falling one
  always @(posedge user_clk)
  begin
    cyc_cnt = cyc_cnt + 1;
    if (run_limit > 0 && cyc_cnt > run_limit)
    begin
      abort_run($sformatf("timeout, the run went past %0d cycles", run_limit));
    end
  end

  always @(negedge user_clk)
  begin
    for (int c = 0; c < NUM_CH; c++)
    begin
      adc_data_i[c] = {lcg_next(), lcg_next()};
    end
    if (cyc_cnt < model.size())
    begin
      model[cyc_cnt] = adc_data_i;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // ##########################################################################
  // failure reporting and compare tasks
  // ##########################################################################
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_ctrl(input string name, input logic [WB_DW-1:0] got,
                            input logic [WB_DW-1:0] exp);
    if (got !== exp)
    begin
      abort_run($sformatf("MISMATCH at %0t: %s got %08h expected %08h",
                          $time, name, got, exp));
    end
  endtask

  task automatic check_sample(input int ch, input int word, input logic half,
                              input logic [WB_DW-1:0] got, input adc_word_t exp_word);
    logic [ADC_WORD_BITS-1:0] flat;
    logic [WB_DW-1:0]         exp;
    flat = exp_word;
    exp  = half ? flat[WB_DW +: WB_DW] : flat[0 +: WB_DW];
    if (got !== exp)
    begin
      abort_run($sformatf("MISMATCH at %0t: wb_dat_o ch%0d word%0d half%0d got %08h expected %08h",
                          $time, ch, word, half, got, exp));
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      abort_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    if (got != exp)
    begin
      abort_run($sformatf("MISMATCH at %0t: %s latency got %0d expected %0d",
                          $time, name, got, exp));
    end
  endtask

  // ##########################################################################
  // bus operations
  // ##########################################################################

  // lat counts falling edges from the request to the response, so 1 is R+1
  task automatic bus_cycle(input logic [WB_AW-1:0] adr, input logic we,
                           input logic [WB_DW-1:0] dat, input logic [WB_SW-1:0] sel,
                           output logic [WB_DW-1:0] rdat, output logic ack,
                           output logic err, output int lat);
    @(negedge user_clk);
    wb_adr_i = adr;
    wb_we_i  = we;
    wb_dat_i = dat;
    wb_sel_i = sel;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    ack      = 1'b0;
    err      = 1'b0;
    rdat     = '0;
    lat      = 0;
    while (!ack && !err)
    begin
      @(negedge user_clk);
      lat++;
      ack  = wb_ack_o;
      err  = wb_err_o;
      rdat = wb_dat_o;
      if (!ack && !err && lat >= RESP_LIMIT)
      begin
        abort_run($sformatf("no ack or err for address %03h after %0d cycles", adr, lat));
      end
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic write_ctrl(input logic [WB_DW-1:0] dat, input logic [WB_SW-1:0] sel,
                            output int ack_cyc);
    logic [WB_DW-1:0] rdat;
    logic             ack;
    logic             err;
    int               lat;
    bus_cycle('0, 1'b1, dat, sel, rdat, ack, err, lat);
    ack_cyc = cyc_cnt;
    check_err("wb_err_o", err, 1'b0);
    check_latency("control write ack", lat, 1);
  endtask

  task automatic read_ctrl(input logic [WB_DW-1:0] exp);
    logic [WB_DW-1:0] rdat;
    logic             ack;
    logic             err;
    int               lat;
    bus_cycle('0, 1'b0, '0, '0, rdat, ack, err, lat);
    check_err("wb_err_o", err, 1'b0);
    check_latency("control read ack", lat, 1);
    check_ctrl("wb_dat_o", rdat, exp);
  endtask

  task automatic probe_err(input logic [WB_AW-1:0] adr, input logic we);
    logic [WB_DW-1:0] rdat;
    logic             ack;
    logic             err;
    int               lat;
    bus_cycle(adr, we, 32'hffff_ffff, '1, rdat, ack, err, lat);
    check_err("wb_err_o", err, 1'b1);
    check_err("wb_ack_o", ack, 1'b0);
    check_latency("err response", lat, 1);
  endtask

  // word i of a window that was armed with ack in cycle base holds cycle base+3+i
  task automatic read_buffer_half(input int ch, input int word, input logic half,
                                  input int base);
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] rdat;
    logic             ack;
    logic             err;
    int               lat;
    adr = WB_AW'((1 << ADR_BUF_BIT) | (ch << ADR_CH_LSB) | (word << ADR_WORD_LSB) |
                 (int'(half) << ADR_HALF_BIT));
    bus_cycle(adr, 1'b0, '0, '0, rdat, ack, err, lat);
    check_err("wb_err_o", err, 1'b0);
    check_latency("buffer read ack", lat, 3);
    check_sample(ch, word, half, rdat, model[base + 3 + word][ch]);
  endtask

  task automatic verify_buffers();
    if (last_a < 0)
    begin
      abort_run("the golden file reads the buffers before any capture");
    end
    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      for (int w = 0; w < DEPTH; w++)
      begin
        read_buffer_half(ch, w, 1'b0, last_a);
        read_buffer_half(ch, w, 1'b1, last_a);
      end
    end
  endtask

  task automatic capture_and_check();
    int ack_cyc;
    write_ctrl(32'h1, 4'h1, ack_cyc);
    write_ctrl(32'h0, 4'h1, ack_cyc);
    last_a = ack_cyc;
    repeat (WINDOW_WAIT) @(negedge user_clk);
    verify_buffers();
  endtask

  // a rising bit 0 alone must leave the last window in place
  task automatic hold_check();
    int ack_cyc;
    write_ctrl(32'h1, 4'h1, ack_cyc);
    repeat (WINDOW_WAIT) @(negedge user_clk);
    verify_buffers();
  endtask

  task automatic probe_channel(input int ch);
    if (ch >= NUM_CH)
    begin
      probe_err(WB_AW'((1 << ADR_BUF_BIT) | (ch << ADR_CH_LSB)), 1'b0);
    end
    else
    begin
      read_buffer_half(ch, 0, 1'b0, last_a);
    end
  endtask

  // ##########################################################################
  // golden file
  // ##########################################################################
  function automatic int arg_count(input logic [7:0] op);
    case (op)
      "W", "E": return 2;
      "R", "X": return 1;
      "C", "S": return 0;
      default:  return -1;
    endcase
  endfunction

  function automatic int op_cost(input logic [7:0] op);
    int reads;
    reads = NUM_CH * DEPTH * 2 * 5;
    case (op)
      "C":     return 12 + WINDOW_WAIT + reads;
      "S":     return 6 + WINDOW_WAIT + reads;
      default: return 6;
    endcase
  endfunction

  task automatic load_golden();
    int          fd;
    int          c;
    int          want;
    int          got;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen(GOLDEN, "r");
    if (fd == 0)
    begin
      abort_run({"cannot open ", GOLDEN});
    end
    while ($fscanf(fd, " %c", op) == 1)
    begin
      a   = '0;
      b   = '0;
      got = 0;
      // a hash starts a comment up to the end of the line
      if (op == "#")
      begin
        c = $fgetc(fd);
        while (c != "\n" && c != -1)
        begin
          c = $fgetc(fd);
        end
      end
      else
      begin
        want = arg_count(op);
        if (want < 0)
        begin
          abort_run($sformatf("unknown operation %c in the golden file", op));
        end
        if (want == 2)
        begin
          got = $fscanf(fd, " %h %h", a, b);
        end
        else if (want == 1)
        begin
          got = $fscanf(fd, " %h", a);
        end
        if (got != want)
        begin
          abort_run($sformatf("operation %c in the golden file lacks its values", op));
        end
        op_code.push_back(op);
        op_a.push_back(a);
        op_b.push_back(b);
      end
    end
    $fclose(fd);
  endtask

  task automatic run_op(input logic [7:0] op, input logic [31:0] a, input logic [31:0] b);
    int ack_cyc;
    case (op)
      "W":     write_ctrl(a, b[WB_SW-1:0], ack_cyc);
      "R":     read_ctrl(a);
      "C":     capture_and_check();
      "S":     hold_check();
      "E":     probe_err(a[WB_AW-1:0], b[0]);
      "X":     probe_channel(int'(a));
      default: abort_run("unknown operation in the golden list");
    endcase
  endtask

  initial
  begin
    int total;
    rst      = 1'b1;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    wb_we_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    load_golden();
    total = RST_CYCLES + MARGIN;
    foreach (op_code[i])
    begin
      total += op_cost(op_code[i]);
    end
    model     = new[total + 1];
    run_limit = total;
    repeat (RST_CYCLES) @(negedge user_clk);
    rst = 1'b0;
    foreach (op_code[i])
    begin
      run_op(op_code[i], op_a[i], op_b[i]);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* adc4x16g_snap.f */
verilog/adc_snap_pkg.sv
verilog/wb_snap_regs.sv
verilog/snap_sequencer.sv
verilog/snap_buffer.sv
verilog/snap_readout.sv
verilog/adc_snap_top.sv
testbench/adc_snap_assert.sv
testbench/adc_snap_tb.sv

/* Makefile */
# Verilator build and run for the ADC snapshot capture subsystem
# The run fails with a non-zero exit status when the testbench stops on $fatal

VERILATOR ?= verilator
TOP       ?= adc_snap_tb
FILELIST  ?= adc4x16g_snap.f
BUILD_DIR ?= obj_dir
NUM_CH    ?= 4
SNAP_AW   ?= 6
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SIM := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR NUM_CH SNAP_AW VFLAGS"

test: $(SIM)
	./$(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) \
		-GNUM_CH=$(NUM_CH) -GSNAP_AW=$(SNAP_AW) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* testbench/adc_snap_golden.txt */
# ops: W data sel = control write, R value = control read with expected value
# C = trigger and full readout, S = set bit 0 only then readout, E addr we = unmapped
# X ch = channel probe, err expected when ch is not below NUM_CH
R 00000000
W a5a5a5a4 f
R a5a5a5a4
W 12345678 2
R a5a556a4
W deadbeef c
R dead56a4
W 00ff0000 4
R deff56a4
W 0000ffff 0
R deff56a4
W 99000000 8
R 99ff56a4
C
R 99ff5600
E 004 0
E 100 1
E 1fc 0
E 800 1
E a08 1
E 200 0
E 600 0
R 99ff5600
X 3
X 2
S
R 99ff5601
W 00000000 2
R 99ff0001
C
R 99ff0000
W 0000ab00 3
R 99ffab00
